// File: verilog/row_fetch_pkg.sv
`default_nettype none

package row_fetch_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  // kernel height, also the bank count
  localparam int KERNEL_ROWS = 3;
  // 4 row lines per bank
  localparam int BANK_LINES_LOG2 = 2;
  // up to 8 words per row
  localparam int MAX_WORDS_LOG2 = 3;
  localparam int BANK_ADDR_W = BANK_LINES_LOG2 + MAX_WORDS_LOG2;
  localparam int DATA_W = 16;
  // signed so that rows above the image can be negative
  localparam int ROW_W = 8;
  // consumer buffer depth, also the credit count at the start of a run
  localparam int CREDITS = 4;
  // issue to output, translator 3 plus memory 1
  localparam int PIPE_LAT = 4;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic signed [ROW_W-1:0] row_t;
  typedef logic [1:0] bank_t;
  typedef logic [BANK_ADDR_W-1:0] bank_addr_t;
  typedef logic [MAX_WORDS_LOG2-1:0] word_idx_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [2:0] credit_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } seq_state_t;

endpackage

`default_nettype wire

// File: verilog/row_fetch_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module row_fetch_sequencer import row_fetch_pkg::*; (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       start,
  input  wire logic [1:0] stride,
  input  wire logic [1:0] pad,
  input  wire row_t       in_height,
  input  wire logic [1:0] words_log2,
  input  wire logic       credit_return,
  output logic            req_valid,
  output row_t            req_row,
  output word_idx_t       req_word,
  output logic            req_last,
  output row_t            cfg_height,
  output logic [1:0]      cfg_words_log2,
  output logic            busy,
  input  wire logic       out_last_seen
);

  seq_state_t state;
  credit_t    credits;

  // configuration held for the whole run
  logic       stride_two_q;
  logic [1:0] pad_q;
  row_t       height_q;
  logic [1:0] wl2_q;
  // index of the last output row
  row_t       oy_last_q;

  // loop counters, oy outer, ky middle, word inner
  row_t       oy_cnt;
  logic [1:0] ky_cnt;
  word_idx_t  word_cnt;
  logic       last_seen;

  logic [MAX_WORDS_LOG2:0] words_per_row;
  word_idx_t               word_last;
  row_t                    oy_scaled;
  logic                    row_end;
  logic                    ky_end;
  logic                    issue;

  assign words_per_row = (MAX_WORDS_LOG2 + 1)'(1) << wl2_q;
  assign word_last     = word_idx_t'(words_per_row - 1'b1);
  assign row_end       = (word_cnt == word_last);
  assign ky_end        = (ky_cnt == 2'(KERNEL_ROWS - 1));

  // one item per cycle while a credit is left
  assign issue = (state == RUN) && (credits != credit_t'(0));

  // input row = oy*stride + ky - pad
  assign oy_scaled = stride_two_q ? (oy_cnt <<< 1) : oy_cnt;

  assign req_valid      = issue;
  assign req_row        = oy_scaled + row_t'(ky_cnt) - row_t'(pad_q);
  assign req_word       = word_cnt;
  assign req_last       = (oy_cnt == oy_last_q) && ky_end && row_end;
  assign cfg_height     = height_q;
  assign cfg_words_log2 = wl2_q;
  assign busy           = (state != IDLE);

  ////////////////////////////////////////
  // configuration latch
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      stride_two_q <= (stride == 2'd2);
      pad_q        <= pad;
      height_q     <= in_height;
      wl2_q        <= words_log2;
      // (h + 2p - 3) / s, i.e. output rows minus one
      oy_last_q    <= (in_height + (row_t'(pad) <<< 1) - row_t'(3)) >>> (stride == 2'd2);
    end
  end

  ////////////////////////////////////////
  // state machine and loops
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      oy_cnt    <= '0;
      ky_cnt    <= '0;
      word_cnt  <= '0;
      last_seen <= 1'b0;
    end else begin
      if (out_last_seen) begin
        last_seen <= 1'b1;
      end
      case (state)
        IDLE: begin
          if (start) begin
            state     <= RUN;
            oy_cnt    <= '0;
            ky_cnt    <= '0;
            word_cnt  <= '0;
            last_seen <= 1'b0;
          end
        end
        RUN: begin
          if (issue) begin
            if (req_last) begin
              state <= DRAIN;
            end
            if (row_end) begin
              word_cnt <= '0;
              if (ky_end) begin
                ky_cnt <= '0;
                oy_cnt <= oy_cnt + row_t'(1);
              end else begin
                ky_cnt <= ky_cnt + 2'd1;
              end
            end else begin
              word_cnt <= word_cnt + word_idx_t'(1);
            end
          end
        end
        DRAIN: begin
          // last item delivered and every credit back from the consumer
          if (last_seen && credits == credit_t'(CREDITS)) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // credit counter
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= credit_t'(CREDITS);
    end else if (issue && !credit_return) begin
      credits <= credits - credit_t'(1);
    end else if (!issue && credit_return && credits != credit_t'(CREDITS)) begin
      // saturate at the consumer depth
      credits <= credits + credit_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: verilog/row_addr_translator.sv
`default_nettype none
`timescale 1ns/1ps

module row_addr_translator import row_fetch_pkg::*; (
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       req_valid,
  input  wire row_t       req_row,
  input  wire word_idx_t  req_word,
  input  wire logic       req_last,
  input  wire row_t       cfg_height,
  input  wire logic [1:0] cfg_words_log2,
  output logic            rd_valid,
  output logic            rd_pad,
  output bank_t           rd_bank,
  output bank_addr_t      rd_addr,
  output logic            rd_last
);

  // stage 1 registers
  logic             s1_valid;
  logic             s1_last;
  logic             s1_pad;
  word_idx_t        s1_word;
  logic [ROW_W-1:0] s1_quot;
  logic [ROW_W-1:0] s1_bias;

  // stage 2 registers
  logic             s2_valid;
  logic             s2_last;
  logic             s2_pad;
  word_idx_t        s2_word;
  bank_t            s2_bank;
  logic [ROW_W-1:0] s2_line;

  logic [ROW_W-1:0] row_u;
  logic [ROW_W-1:0] quot0;
  logic [ROW_W-1:0] bias0;
  logic             row_is_pad;
  logic [BANK_LINES_LOG2-1:0] line_masked;

  ////////////////////////////////////////
  // stage 1 padding and base in threes
  ////////////////////////////////////////

  // row/4 never overshoots row/3
  assign row_u      = req_row;
  assign quot0      = row_u >> 2;
  // row - 3*quot0, wraps harmlessly since the true value is small
  assign bias0      = row_u - ((quot0 << 1) + quot0);
  assign row_is_pad = (req_row < row_t'(0)) || (req_row >= cfg_height);

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
    end else begin
      s1_valid <= req_valid;
      s1_last  <= req_last;
    end
  end

  always_ff @(posedge clk) begin
    s1_pad  <= row_is_pad;
    s1_word <= req_word;
    s1_quot <= quot0;
    s1_bias <= bias0;
  end

  ////////////////////////////////////////
  // stage 2 bias correction
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
      s2_last  <= s1_last;
    end
  end

  // bias stays below 6 for every row under the height limit,
  // so one step brings it into 0..2
  // padding rows may land anywhere, their bank is dropped in stage 3
  always_ff @(posedge clk) begin
    s2_pad  <= s1_pad;
    s2_word <= s1_word;
    if (s1_bias >= 8'd3) begin
      s2_bank <= bank_t'(s1_bias - 8'd3);
      s2_line <= s1_quot + 8'd1;
    end else begin
      s2_bank <= bank_t'(s1_bias);
      s2_line <= s1_quot;
    end
  end

  ////////////////////////////////////////
  // stage 3 word address
  ////////////////////////////////////////

  // line wraps around the bank depth
  assign line_masked = s2_line[BANK_LINES_LOG2-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
      rd_last  <= 1'b0;
    end else begin
      rd_valid <= s2_valid;
      rd_last  <= s2_last;
    end
  end

  always_ff @(posedge clk) begin
    rd_pad <= s2_pad;
    if (s2_pad) begin
      // padding rows point nowhere in particular
      rd_bank <= '0;
      rd_addr <= '0;
    end else begin
      rd_bank <= s2_bank;
      // line * words_per_row + word
      rd_addr <= (bank_addr_t'(line_masked) << cfg_words_log2) + bank_addr_t'(s2_word);
    end
  end

endmodule

`default_nettype wire

// File: verilog/row_bank_memory.sv
`default_nettype none
`timescale 1ns/1ps

module row_bank_memory import row_fetch_pkg::*; (
  input  wire logic       clk,
  input  wire logic       reset,
  // raw load port
  input  wire logic       wr_en,
  input  wire bank_t      wr_bank,
  input  wire bank_addr_t wr_addr,
  input  wire data_t      wr_data,
  // read request from the translator
  input  wire logic       rd_valid,
  input  wire logic       rd_pad,
  input  wire bank_t      rd_bank,
  input  wire bank_addr_t rd_addr,
  input  wire logic       rd_last,
  // stream toward the consumer
  output logic            out_valid,
  output data_t           out_data,
  output logic            out_pad,
  output logic            out_last
);

  localparam int BANK_WORDS = 1 << BANK_ADDR_W;

  // one line buffer per kernel row
  data_t bank_mem [KERNEL_ROWS][BANK_WORDS];

  ////////////////////////////////////////
  // load port
  ////////////////////////////////////////

  // bank 3 does not exist, writes there are dropped
  always_ff @(posedge clk) begin
    if (wr_en && wr_bank < bank_t'(KERNEL_ROWS)) begin
      bank_mem[wr_bank][wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // registered read
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      // padding items carry zeros and skip the array
      if (rd_pad) begin
        out_data <= '0;
      end else begin
        out_data <= bank_mem[rd_bank][rd_addr];
      end
    end
  end

  // flags
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_pad   <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= rd_valid;
      out_pad   <= rd_valid && rd_pad;
      out_last  <= rd_valid && rd_last;
    end
  end

endmodule

`default_nettype wire

// File: verilog/row_fetch_top.sv
`default_nettype none
`timescale 1ns/1ps

module row_fetch_top import row_fetch_pkg::*; (
  input  wire logic       clk,
  input  wire logic       reset,
  // configuration, sampled on start
  input  wire logic [1:0] stride,
  input  wire logic [1:0] pad,
  input  wire row_t       in_height,
  input  wire logic [1:0] words_log2,
  input  wire logic       start,
  // memory load
  input  wire logic       wr_en,
  input  wire bank_t      wr_bank,
  input  wire bank_addr_t wr_addr,
  input  wire data_t      wr_data,
  // output stream and credits
  output logic            out_valid,
  output data_t           out_data,
  output logic            out_pad,
  output logic            out_last,
  input  wire logic       credit_return,
  output logic            busy
);

  // sequencer to translator
  logic       req_valid;
  row_t       req_row;
  word_idx_t  req_word;
  logic       req_last;
  row_t       cfg_height;
  logic [1:0] cfg_words_log2;

  // translator to memory
  logic       rd_valid;
  logic       rd_pad;
  bank_t      rd_bank;
  bank_addr_t rd_addr;
  logic       rd_last;

  row_fetch_sequencer sequencer_inst (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .stride         (stride),
    .pad            (pad),
    .in_height      (in_height),
    .words_log2     (words_log2),
    .credit_return  (credit_return),
    .req_valid      (req_valid),
    .req_row        (req_row),
    .req_word       (req_word),
    .req_last       (req_last),
    .cfg_height     (cfg_height),
    .cfg_words_log2 (cfg_words_log2),
    .busy           (busy),
    .out_last_seen  (out_last)
  );

  row_addr_translator translator_inst (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (req_valid),
    .req_row        (req_row),
    .req_word       (req_word),
    .req_last       (req_last),
    .cfg_height     (cfg_height),
    .cfg_words_log2 (cfg_words_log2),
    .rd_valid       (rd_valid),
    .rd_pad         (rd_pad),
    .rd_bank        (rd_bank),
    .rd_addr        (rd_addr),
    .rd_last        (rd_last)
  );

  row_bank_memory memory_inst (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (wr_en),
    .wr_bank   (wr_bank),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_valid  (rd_valid),
    .rd_pad    (rd_pad),
    .rd_bank   (rd_bank),
    .rd_addr   (rd_addr),
    .rd_last   (rd_last),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_pad   (out_pad),
    .out_last  (out_last)
  );

endmodule

`default_nettype wire

// File: testbench/row_fetch_assert.sv
`default_nettype none
`timescale 1ns/1ps

module row_fetch_assert import row_fetch_pkg::*; (
  input wire logic    clk,
  input wire logic    reset,
  input wire logic    req_valid,
  input wire logic    busy,
  input wire logic    out_valid,
  input wire logic    out_pad,
  input wire data_t   out_data,
  input wire credit_t credits
);

  // credit counter saturates at the consumer depth
  credit_limit: assert property (@(posedge clk) disable iff (reset)
    credits <= credit_t'(CREDITS))
    else $error("credit count above the consumer depth");

  // padding items carry zero data
  pad_zero: assert property (@(posedge clk) disable iff (reset)
    out_pad |-> (out_data == '0))
    else $error("padding item with nonzero data");

  // fixed pipeline, no stall anywhere
  issue_latency: assert property (@(posedge clk) disable iff (reset)
    req_valid |-> ##PIPE_LAT out_valid)
    else $error("issued item missing at the output");

  // issue only inside a run
  issue_busy: assert property (@(posedge clk) disable iff (reset)
    !busy |-> !req_valid)
    else $error("request issued while idle");

endmodule

`default_nettype wire

// File: testbench/row_fetch_tb.sv
`default_nettype none
`timescale 1ns/1ps

module row_fetch_tb import row_fetch_pkg::*; ();

  ////////////////////////////////////////
  // run table
  ////////////////////////////////////////

  localparam int MAX_ROWS  = KERNEL_ROWS << BANK_LINES_LOG2;
  localparam int MAX_WORDS = 1 << MAX_WORDS_LOG2;
  localparam int NUM_RUNS  = 6;

  // pad rows top and bottom, all banks up to line 3, padding both sides,
  // long credit holds, then two back-to-back runs with new configurations
  localparam int RUN_STRIDE [NUM_RUNS] = '{1, 2, 2, 1, 1, 2};
  localparam int RUN_PAD    [NUM_RUNS] = '{1, 0, 2, 0, 2, 1};
  localparam int RUN_HEIGHT [NUM_RUNS] = '{8, 12, 5, 12, 3, 9};
  localparam int RUN_WL2    [NUM_RUNS] = '{2, 3, 0, 1, 3, 1};
  // largest credit return delay in cycles
  localparam int RUN_HOLD   [NUM_RUNS] = '{5, 5, 5, 40, 3, 0};

  logic       clk;
  logic       reset;
  logic [1:0] stride;
  logic [1:0] pad;
  row_t       in_height;
  logic [1:0] words_log2;
  logic       start;
  logic       wr_en;
  bank_t      wr_bank;
  bank_addr_t wr_addr;
  data_t      wr_data;
  logic       out_valid;
  data_t      out_data;
  logic       out_pad;
  logic       out_last;
  logic       credit_return;
  logic       busy;

  // copy of the image rows, indexed by row and word
  data_t row_data [MAX_ROWS][MAX_WORDS];

  // configuration of the run in progress
  int cur_run;
  int cur_stride;
  int cur_pad;
  int cur_height;
  int cur_wl2;
  int exp_total;
  int cmp_count;
  int last_count;
  int hold_max = 5;

  int check_count = 0;
  int error_count = 0;

  logic [31:0] fill_state  = 32'd84;
  logic [31:0] delay_state = 32'd84;

  // items waiting in the consumer buffer, {last, pad, data}
  logic [DATA_W+1:0] rx_q [$];

  row_fetch_top row_fetch_inst (
    .clk           (clk),
    .reset         (reset),
    .stride        (stride),
    .pad           (pad),
    .in_height     (in_height),
    .words_log2    (words_log2),
    .start         (start),
    .wr_en         (wr_en),
    .wr_bank       (wr_bank),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_pad       (out_pad),
    .out_last      (out_last),
    .credit_return (credit_return),
    .busy          (busy)
  );

  bind row_fetch_top row_fetch_assert assert_inst (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .busy      (busy),
    .out_valid (out_valid),
    .out_pad   (out_pad),
    .out_data  (out_data),
    .credits   (sequencer_inst.credits)
  );

  // 4 ns clock
  initial clk = 1'b0;
  always #2 clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int item_count(input int s, input int p, input int h, input int wl2);
    // output rows times kernel rows times words per row
    return ((h + 2 * p - KERNEL_ROWS) / s + 1) * KERNEL_ROWS * (1 << wl2);
  endfunction

  // expected {last, pad, data} for item idx of the current run
  function automatic logic [DATA_W+1:0] expected_item(input int idx);
    int    per_row;
    int    w;
    int    ky;
    int    oy;
    int    r;
    logic  is_pad;
    data_t d;
    per_row = 1 << cur_wl2;
    w  = idx % per_row;
    ky = (idx / per_row) % KERNEL_ROWS;
    oy = idx / (per_row * KERNEL_ROWS);
    // input row from output row and kernel row
    r  = oy * cur_stride + ky - cur_pad;
    is_pad = (r < 0) || (r >= cur_height);
    d = '0;
    if (!is_pad) begin
      d = row_data[r][w];
    end
    return {(idx == exp_total - 1), is_pad, d};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  // fresh random rows through the raw write port
  task automatic load_memory(input int h, input int wl2);
    int    line;
    data_t d;
    for (int r = 0; r < h; r++) begin
      for (int w = 0; w < (1 << wl2); w++) begin
        fill_state = xorshift32(fill_state);
        d = fill_state[DATA_W-1:0];
        row_data[r][w] = d;
        // bank r mod 3, line r div 3 wrapped to the bank depth
        line = (r / KERNEL_ROWS) % (1 << BANK_LINES_LOG2);
        @(negedge clk);
        wr_en   = 1'b1;
        wr_bank = bank_t'(r % KERNEL_ROWS);
        wr_addr = bank_addr_t'((line << wl2) + w);
        wr_data = d;
      end
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic consume_item(input logic [DATA_W+1:0] item);
    logic [DATA_W+1:0] want;
    if (cmp_count >= exp_total) begin
      error_count++;
      $display("run %0d delivered more items than the %0d expected", cur_run, exp_total);
    end else begin
      want = expected_item(cmp_count);
      check_value($sformatf("run%0d item%0d data", cur_run, cmp_count),
                  32'(want[DATA_W-1:0]), 32'(item[DATA_W-1:0]));
      check_value($sformatf("run%0d item%0d pad", cur_run, cmp_count),
                  32'(want[DATA_W]), 32'(item[DATA_W]));
      check_value($sformatf("run%0d item%0d last", cur_run, cmp_count),
                  32'(want[DATA_W+1]), 32'(item[DATA_W+1]));
    end
    if (item[DATA_W+1]) begin
      last_count++;
    end
    cmp_count++;
  endtask

  task automatic do_run(input int run);
    int s;
    int p;
    int h;
    int wl2;
    s   = RUN_STRIDE[run];
    p   = RUN_PAD[run];
    h   = RUN_HEIGHT[run];
    wl2 = RUN_WL2[run];
    load_memory(h, wl2);
    cur_run    = run;
    cur_stride = s;
    cur_pad    = p;
    cur_height = h;
    cur_wl2    = wl2;
    hold_max   = RUN_HOLD[run];
    exp_total  = item_count(s, p, h, wl2);
    cmp_count  = 0;
    last_count = 0;
    @(negedge clk);
    stride     = 2'(s);
    pad        = 2'(p);
    in_height  = row_t'(h);
    words_log2 = 2'(wl2);
    start      = 1'b1;
    @(negedge clk);
    start = 1'b0;
    // config inputs move during the run, the DUT works from its own copy
    stride    = (s == 1) ? 2'd2 : 2'd1;
    pad       = 2'(2 - p);
    in_height = row_t'(MAX_ROWS);
    check_value($sformatf("run%0d busy after start", run), 32'd1, 32'(busy));
    while (busy) begin
      @(negedge clk);
    end
    check_value($sformatf("run%0d item count", run), 32'(exp_total), 32'(cmp_count));
    check_value($sformatf("run%0d out_last count", run), 32'd1, 32'(last_count));
    check_value($sformatf("run%0d out_valid when idle", run), 32'd0, 32'(out_valid));
  endtask

  ////////////////////////////////////////
  // consumer with credit return
  ////////////////////////////////////////

  initial begin : consumer
    int delay;
    credit_return = 1'b0;
    delay = 0;
    forever begin
      @(negedge clk);
      credit_return = 1'b0;
      if (out_valid) begin
        rx_q.push_back({out_last, out_pad, out_data});
      end
      // one buffered item leaves per credit pulse
      if (rx_q.size() > 0) begin
        if (delay == 0) begin
          consume_item(rx_q.pop_front());
          credit_return = 1'b1;
          delay_state = xorshift32(delay_state);
          delay = int'(delay_state % 32'(hold_max + 1));
        end else begin
          delay--;
        end
      end
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : main
    reset      = 1'b1;
    start      = 1'b0;
    stride     = 2'd1;
    pad        = 2'd0;
    in_height  = row_t'(KERNEL_ROWS);
    words_log2 = 2'd0;
    wr_en      = 1'b0;
    wr_bank    = '0;
    wr_addr    = '0;
    wr_data    = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    // nothing moves before the first start
    repeat (20) begin
      @(negedge clk);
      check_value("idle after reset out_valid", 32'd0, 32'(out_valid));
      check_value("idle after reset busy", 32'd0, 32'(busy));
    end
    for (int run = 0; run < NUM_RUNS; run++) begin
      do_run(run);
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // budget of 40 cycles per item plus 200, and one per load write
  initial begin : watchdog
    int budget;
    budget = 200;
    for (int run = 0; run < NUM_RUNS; run++) begin
      budget += 40 * item_count(RUN_STRIDE[run], RUN_PAD[run], RUN_HEIGHT[run], RUN_WL2[run]);
      budget += RUN_HEIGHT[run] << RUN_WL2[run];
    end
    repeat (budget) @(posedge clk);
    $display("watchdog expired after %0d cycles, the DUT stopped finishing runs", budget);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: row_fetch.f
verilog/row_fetch_pkg.sv
verilog/row_fetch_sequencer.sv
verilog/row_addr_translator.sv
verilog/row_bank_memory.sv
verilog/row_fetch_top.sv
testbench/row_fetch_assert.sv
testbench/row_fetch_tb.sv

// File: Makefile
# Verilator build and run for the row fetch testbench

VERILATOR ?= verilator
TOP       ?= row_fetch_tb
FILELIST  ?= row_fetch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
